//--- spis_pkg.sv
// SPI slave register port
// Shared widths, command opcodes and controller state encoding

package spis_pkg;

	//////////////////////////////////////////////////
	// Widths

	localparam int SPIS_DATA_W = 32;  // Data word and shift word
	localparam int SPIS_ADDR_W = 16;  // Register address field
	localparam int SPIS_LEN_W  = 8;   // Burst length field

	//////////////////////////////////////////////////
	// Command opcodes, bits 31..24 of the command word

	localparam logic [7:0] SPIS_OP_RD  = 8'h00;  // Single read
	localparam logic [7:0] SPIS_OP_WR  = 8'h01;  // Single write
	localparam logic [7:0] SPIS_OP_BRD = 8'h20;  // Burst read
	localparam logic [7:0] SPIS_OP_BWR = 8'h21;  // Burst write

	//////////////////////////////////////////////////
	// Controller states

	typedef enum logic [2:0] {
		IDLE   = 3'h0,  // Waiting for a command word
		CMD    = 3'h1,  // Decode and load counters
		RD     = 3'h2,  // Waiting for the read slot
		FRD    = 3'h3,
		WR     = 3'h4,  // Waiting for a data word
		FWR    = 3'h5,
		END_WR = 3'h6,
		END_RD = 3'h7
	} spis_state_t;

endpackage

//--- spis_shift.sv
`timescale 1ns/1ps
// SPI mode 0 shifter
// Tracks ss_n, assembles words from mosi, shifts reply words out on miso
// and marks the word boundaries for the controller

module spis_shift (
	input  logic                             sclk,
	input  logic                             rst_n,
	input  logic                             ss_n,
	input  logic                             mosi,
	input  logic [spis_pkg::SPIS_DATA_W-1:0] tx_word,
	output logic                             miso,
	output logic                             ss_off,
	output logic                             ss_idle,
	output logic                             word_rx,
	output logic [spis_pkg::SPIS_DATA_W-1:0] rx_word,
	output logic                             rd_slot,
	output logic                             word_tx
);
	import spis_pkg::*;

	localparam int CNT_W = $clog2(SPIS_DATA_W);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SPIS_DATA_W - 1);
	localparam logic [CNT_W-1:0] CNT_SLOT = CNT_W'(SPIS_DATA_W - 4);  // Bit 28

	logic                   ss_neg;       // ss_n seen on falling edge
	logic                   ss_pos;       // Same, carried to rising edge
	logic [CNT_W-1:0]       rx_cnt;
	logic [CNT_W-1:0]       tx_cnt;
	logic [SPIS_DATA_W-1:0] rx_shift;
	logic [SPIS_DATA_W-1:0] tx_hold;      // Reply word taken at the read slot
	logic [SPIS_DATA_W-1:0] tx_shift;
	logic                   word_flag;    // Toggles on every full word
	logic                   word_flag_q;

	//////////////////////////////////////////////////
	// Slave select tracking

	always_ff @(negedge sclk or negedge rst_n) begin
		if (!rst_n)
			ss_neg <= 1'b1;
		else
			ss_neg <= ss_n;
	end

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n)
			ss_pos <= 1'b1;
		else
			ss_pos <= ss_neg;
	end

	assign ss_idle = ss_n & ss_neg & ss_pos;  // Synchronous clear for all logic
	assign ss_off  = ss_n & ~ss_pos;

	//////////////////////////////////////////////////
	// Receive, mosi sampled on rising sclk

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			rx_cnt      <= '0;
			word_flag   <= 1'b0;
			word_flag_q <= 1'b0;
		end else if (ss_idle) begin
			rx_cnt      <= '0;
			word_flag   <= 1'b0;
			word_flag_q <= 1'b0;
		end else begin
			rx_cnt      <= rx_cnt + 1'b1;
			word_flag_q <= word_flag;
			if (rx_cnt == CNT_LAST)
				word_flag <= ~word_flag;
		end
	end

	always_ff @(posedge sclk) begin
		if (!ss_idle)
			rx_shift <= {rx_shift[SPIS_DATA_W-2:0], mosi};  // MSB first
	end

	assign word_rx = word_flag ^ word_flag_q;  // Cycle after the 32nd bit
	assign rx_word = rx_shift;

	//////////////////////////////////////////////////
	// Transmit, miso launched on falling sclk

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			tx_cnt  <= '0;
			word_tx <= 1'b0;
			tx_hold <= '0;
		end else if (ss_idle) begin
			tx_cnt  <= '0;
			word_tx <= 1'b0;
			tx_hold <= '0;
		end else begin
			tx_cnt  <= tx_cnt + 1'b1;
			word_tx <= (tx_cnt == CNT_LAST);
			if (rd_slot)
				tx_hold <= tx_word;
		end
	end

	assign rd_slot = (tx_cnt == CNT_SLOT);

	// Loads on the falling edge right after the word boundary
	always_ff @(negedge sclk or negedge rst_n) begin
		if (!rst_n)
			tx_shift <= '0;
		else if (ss_idle)
			tx_shift <= '0;
		else if (word_tx)
			tx_shift <= tx_hold;
		else
			tx_shift <= {tx_shift[SPIS_DATA_W-2:0], 1'b0};
	end

	assign miso = tx_shift[SPIS_DATA_W-1] & ~ss_idle;

endmodule

//--- spis_ctrl.sv
`timescale 1ns/1ps
// SPI slave command controller
// Captures the command word, runs single and burst accesses with an
// incrementing address and drives the register file strobes

module spis_ctrl (
	input  logic                             sclk,
	input  logic                             rst_n,
	input  logic                             ss_idle,
	input  logic                             word_rx,
	input  logic [spis_pkg::SPIS_DATA_W-1:0] rx_word,
	input  logic                             rd_slot,
	input  logic                             word_tx,
	input  logic [spis_pkg::SPIS_DATA_W-1:0] rd_data,
	output logic [spis_pkg::SPIS_DATA_W-1:0] tx_word,
	output logic                             wr_en,
	output logic [spis_pkg::SPIS_ADDR_W-1:0] wr_addr,
	output logic [spis_pkg::SPIS_DATA_W-1:0] wr_data,
	output logic                             rd_en,
	output logic [spis_pkg::SPIS_ADDR_W-1:0] rd_addr,
	output logic [spis_pkg::SPIS_DATA_W-1:0] dbg_bus
);
	import spis_pkg::*;

	spis_state_t            cur_st;
	spis_state_t            nxt_st;
	logic                   cmd_seen;   // Command taken in this frame
	logic                   cmd_load;
	logic [7:0]             cmd_op;
	logic [SPIS_LEN_W-1:0]  cmd_len;
	logic [SPIS_ADDR_W-1:0] cmd_addr;
	logic                   is_rd;
	logic                   is_wr;
	logic [SPIS_LEN_W-1:0]  burst_len;
	logic [SPIS_LEN_W-1:0]  burst_cnt;  // Accesses still to do
	logic [SPIS_ADDR_W-1:0] addr_cnt;

	//////////////////////////////////////////////////
	// Command capture, first word of the frame only

	assign cmd_load = word_rx & ~cmd_seen;

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_seen <= 1'b0;
			cmd_op   <= 8'hff;  // Unused opcode
			cmd_len  <= '0;
			cmd_addr <= '0;
		end else if (ss_idle) begin
			cmd_seen <= 1'b0;
			cmd_op   <= 8'hff;
			cmd_len  <= '0;
			cmd_addr <= '0;
		end else if (cmd_load) begin
			cmd_seen <= 1'b1;
			cmd_op   <= rx_word[SPIS_DATA_W-1 -: 8];
			cmd_len  <= rx_word[SPIS_ADDR_W +: SPIS_LEN_W];
			cmd_addr <= rx_word[SPIS_ADDR_W-1:0];
		end
	end

	always_comb begin
		is_rd     = 1'b0;
		is_wr     = 1'b0;
		burst_len = SPIS_LEN_W'(1);
		case (cmd_op)
			SPIS_OP_RD: is_rd = 1'b1;
			SPIS_OP_WR: is_wr = 1'b1;
			SPIS_OP_BRD: begin
				is_rd = 1'b1;
				if (cmd_len != '0)
					burst_len = cmd_len;  // Zero length runs once
			end
			SPIS_OP_BWR: begin
				is_wr = 1'b1;
				if (cmd_len != '0)
					burst_len = cmd_len;
			end
			default: burst_len = '0;  // Ignored until ss_n rises
		endcase
	end

	//////////////////////////////////////////////////
	// Burst FSM

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n)
			cur_st <= IDLE;
		else if (ss_idle)
			cur_st <= IDLE;
		else
			cur_st <= nxt_st;
	end

	always_comb begin
		nxt_st = cur_st;
		case (cur_st)
			IDLE: begin
				if (cmd_load)
					nxt_st = CMD;
			end
			CMD: begin
				if (is_rd)
					nxt_st = RD;
				else if (is_wr)
					nxt_st = WR;
				else
					nxt_st = IDLE;
			end
			WR: begin
				if (wr_en)
					nxt_st = FWR;
			end
			FWR: nxt_st = (burst_cnt == '0) ? END_WR : WR;
			RD: begin
				if (rd_en)
					nxt_st = FRD;
			end
			FRD: begin
				if (word_tx)  // Hold until the fetched word is in flight
					nxt_st = (burst_cnt == '0) ? END_RD : RD;
			end
			default: nxt_st = IDLE;
		endcase
	end

	// Address and remaining count, one step per access
	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			burst_cnt <= '0;
			addr_cnt  <= '0;
		end else if (ss_idle) begin
			burst_cnt <= '0;
			addr_cnt  <= '0;
		end else if (cur_st == CMD) begin
			burst_cnt <= burst_len;
			addr_cnt  <= cmd_addr;
		end else if (wr_en || rd_en) begin
			burst_cnt <= burst_cnt - 1'b1;
			addr_cnt  <= addr_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Register file strobes

	assign wr_en   = (cur_st == WR) & word_rx & ~ss_idle;
	assign rd_en   = (cur_st == RD) & rd_slot & ~ss_idle;  // Fetch for the next word
	assign wr_addr = addr_cnt;
	assign rd_addr = addr_cnt;
	assign wr_data = rx_word;
	assign tx_word = rd_en ? rd_data : '0;

	assign dbg_bus = SPIS_DATA_W'({cur_st, burst_cnt, cmd_len});

endmodule

//--- spis_regfile.sv
`timescale 1ns/1ps
// Register file for the SPI slave
// REG_DEPTH words with a synchronous write port and a combinational
// read port, out of range accesses are dropped or read as zero

module spis_regfile #(
	parameter int REG_DEPTH = 16
) (
	input  logic                             sclk,
	input  logic                             rst_n,
	input  logic                             wr_en,
	input  logic [spis_pkg::SPIS_ADDR_W-1:0] wr_addr,
	input  logic [spis_pkg::SPIS_DATA_W-1:0] wr_data,
	input  logic                             rd_en,
	input  logic [spis_pkg::SPIS_ADDR_W-1:0] rd_addr,
	output logic [spis_pkg::SPIS_DATA_W-1:0] rd_data
);
	import spis_pkg::*;

	localparam int IDX_W = (REG_DEPTH > 1) ? $clog2(REG_DEPTH) : 1;

	logic [SPIS_DATA_W-1:0] regs [REG_DEPTH];
	logic                   wr_hit;
	logic                   rd_hit;

	assign wr_hit = wr_en && (wr_addr < REG_DEPTH);
	assign rd_hit = rd_en && (rd_addr < REG_DEPTH);

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_hit) begin
			regs[wr_addr[IDX_W-1:0]] <= wr_data;
		end
	end

	// Zero outside the array or when no read is pending
	assign rd_data = rd_hit ? regs[rd_addr[IDX_W-1:0]] : '0;

endmodule

//--- spis_top.sv
`timescale 1ns/1ps
// SPI slave register port, mode 0
// Shifter, command controller and register file on the SPI clock

module spis_top #(
	parameter int REG_DEPTH = 16
) (
	input  logic                             sclk,
	input  logic                             rst_n,
	input  logic                             ss_n,
	input  logic                             mosi,
	output logic                             miso,
	output logic [spis_pkg::SPIS_DATA_W-1:0] dbg_bus
);
	import spis_pkg::*;

	logic                   ss_idle;
	logic                   word_rx;
	logic                   rd_slot;
	logic                   word_tx;
	logic [SPIS_DATA_W-1:0] rx_word;
	logic [SPIS_DATA_W-1:0] tx_word;
	logic                   wr_en;
	logic                   rd_en;
	logic [SPIS_ADDR_W-1:0] wr_addr;
	logic [SPIS_ADDR_W-1:0] rd_addr;
	logic [SPIS_DATA_W-1:0] wr_data;
	logic [SPIS_DATA_W-1:0] rd_data;

	spis_shift shift_i (
		.sclk    (sclk),
		.rst_n   (rst_n),
		.ss_n    (ss_n),
		.mosi    (mosi),
		.tx_word (tx_word),
		.miso    (miso),
		.ss_off  (),
		.ss_idle (ss_idle),
		.word_rx (word_rx),
		.rx_word (rx_word),
		.rd_slot (rd_slot),
		.word_tx (word_tx)
	);

	spis_ctrl ctrl_i (
		.sclk    (sclk),
		.rst_n   (rst_n),
		.ss_idle (ss_idle),
		.word_rx (word_rx),
		.rx_word (rx_word),
		.rd_slot (rd_slot),
		.word_tx (word_tx),
		.rd_data (rd_data),
		.tx_word (tx_word),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.dbg_bus (dbg_bus)
	);

	spis_regfile #(
		.REG_DEPTH (REG_DEPTH)
	) regfile_i (
		.sclk    (sclk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

//--- spis_chk.sv
`timescale 1ns/1ps
// Protocol checks for the SPI slave controller
// Bound into spis_ctrl, watches the strobes and the state register

module spis_chk (
	input logic                  sclk,
	input logic                  rst_n,
	input logic                  ss_idle,
	input logic                  wr_en,
	input logic                  rd_en,
	input spis_pkg::spis_state_t cur_st
);
	import spis_pkg::*;

	int unsigned fail_cnt = 0;  // Read by the testbench at the end

	// One register access per cycle
	a_rw_excl: assert property (@(posedge sclk) disable iff (!rst_n) !(wr_en && rd_en))
		else begin
			$error("wr_en and rd_en high in the same cycle");
			fail_cnt++;
		end

	a_idle_clear: assert property (@(posedge sclk) disable iff (!rst_n)
		ss_idle |=> (cur_st == IDLE))
		else begin
			$error("controller not in IDLE after ss_idle");
			fail_cnt++;
		end

	a_no_wr_idle: assert property (@(posedge sclk) disable iff (!rst_n)
		(cur_st == IDLE) |-> !wr_en)
		else begin
			$error("wr_en high in IDLE");
			fail_cnt++;
		end

endmodule

bind spis_ctrl spis_chk chk_i (
	.sclk    (sclk),
	.rst_n   (rst_n),
	.ss_idle (ss_idle),
	.wr_en   (wr_en),
	.rd_en   (rd_en),
	.cur_st  (cur_st)
);

//--- tb_spis.sv
`timescale 1ns/1ps
// Testbench for the SPI slave register port
// Plays SPI frames from the transaction file and checks miso against
// a register model of the slave

module tb_spis;
	import spis_pkg::*;

	localparam int REG_DEPTH = 16;
	localparam int T_HALF    = 50;   // 100 ns sclk period
	localparam int TIMEOUT   = 200;  // Cycles per wait loop
	localparam int RD_LAG    = 2;    // Reply data starts two words after the command
	localparam int TD_SIZE   = 256;

	logic                   sclk;
	logic                   rst_n;
	logic                   ss_n;
	logic                   mosi;
	logic                   miso;
	logic [SPIS_DATA_W-1:0] dbg_bus;

	logic [SPIS_DATA_W-1:0] tdata [TD_SIZE];    // Flat transaction list
	logic [SPIS_DATA_W-1:0] model [REG_DEPTH];  // Expected register contents
	int                     err_cnt;
	int                     chk_cnt;
	int                     test_cnt;
	bit                     timed_out;

	spis_top #(
		.REG_DEPTH (REG_DEPTH)
	) dut_i (
		.sclk    (sclk),
		.rst_n   (rst_n),
		.ss_n    (ss_n),
		.mosi    (mosi),
		.miso    (miso),
		.dbg_bus (dbg_bus)
	);

	initial sclk = 1'b0;
	always #(T_HALF) sclk = ~sclk;

	//////////////////////////////////////////////////
	// Register model

	function automatic int burst_count(input logic [7:0] op, input logic [7:0] len);
		if (op == SPIS_OP_RD || op == SPIS_OP_WR)
			return 1;
		else if (op == SPIS_OP_BRD || op == SPIS_OP_BWR)
			return (len == 8'h00) ? 1 : int'(len);  // Zero length runs once
		else
			return 0;  // Unknown opcode does nothing
	endfunction

	function automatic bit is_read(input logic [7:0] op);
		return (op == SPIS_OP_RD || op == SPIS_OP_BRD);
	endfunction

	function automatic bit is_write(input logic [7:0] op);
		return (op == SPIS_OP_WR || op == SPIS_OP_BWR);
	endfunction

	function automatic logic [SPIS_DATA_W-1:0] model_read(input logic [SPIS_ADDR_W-1:0] addr);
		if (addr < REG_DEPTH)
			return model[addr];
		return '0;  // Out of range reads as zero
	endfunction

	task automatic model_write(input logic [SPIS_ADDR_W-1:0] addr,
			input logic [SPIS_DATA_W-1:0] data);
		if (addr < REG_DEPTH)
			model[addr] = data;
	endtask

	//////////////////////////////////////////////////
	// SPI frame helpers

	task automatic check_value(input string name, input logic [SPIS_DATA_W-1:0] exp,
			input logic [SPIS_DATA_W-1:0] got);
		chk_cnt++;
		assert (got === exp) else begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			err_cnt++;
		end
	endtask

	// MSB first, mosi set on the falling edge, miso taken on the rising edge
	task automatic shift_word(input logic [SPIS_DATA_W-1:0] word, input int nbits,
			output logic [SPIS_DATA_W-1:0] got);
		got = '0;
		for (int b = 0; b < nbits; b++) begin
			@(negedge sclk);
			ss_n <= 1'b0;
			mosi <= word[SPIS_DATA_W-1-b];
			@(posedge sclk);
			got = {got[SPIS_DATA_W-2:0], miso};
		end
	endtask

	task automatic close_frame();
		int cyc;
		@(negedge sclk);
		ss_n <= 1'b1;
		mosi <= 1'b0;
		cyc = 0;
		// At least 3 idle cycles, then until the controller has cleared
		while ((cyc < 3 || dbg_bus !== '0) && cyc < TIMEOUT) begin
			@(negedge sclk);
			cyc++;
		end
		if (dbg_bus !== '0) begin
			$display("Timeout: controller did not return to idle after ss_n rose");
			timed_out = 1'b1;
		end
	endtask

	task automatic play_frame(input int base, output int nxt_ptr);
		logic [SPIS_DATA_W-1:0] cmd;
		logic [SPIS_DATA_W-1:0] ctl;
		logic [SPIS_DATA_W-1:0] got;
		logic [SPIS_DATA_W-1:0] exp;
		logic [7:0]             op;
		logic [SPIS_ADDR_W-1:0] addr;
		int                     n_data;
		int                     cut;
		int                     burst;
		int                     nbits;
		cmd    = tdata[base+1];
		ctl    = tdata[base+2];
		op     = cmd[31:24];
		addr   = cmd[15:0];
		n_data = int'(ctl[15:0]);
		cut    = int'(ctl[31:16]);  // Bits sent of the last word before abort
		burst  = burst_count(op, cmd[23:16]);
		for (int j = 0; j <= n_data; j++) begin
			nbits = (j == n_data && cut != 0) ? cut : SPIS_DATA_W;
			shift_word((j == 0) ? cmd : tdata[base+2+j], nbits, got);
			if (nbits == SPIS_DATA_W) begin
				exp = '0;
				if (is_read(op) && j >= RD_LAG && j - RD_LAG < burst)
					exp = model_read(addr + SPIS_ADDR_W'(j - RD_LAG));
				check_value($sformatf("miso word %0d", j), exp, got);
				// Only whole data words reach the registers
				if (is_write(op) && j >= 1 && j - 1 < burst)
					model_write(addr + SPIS_ADDR_W'(j - 1), tdata[base+2+j]);
			end
		end
		close_frame();
		nxt_ptr = base + 3 + n_data;
	endtask

	task automatic report_test(input int num, input int frames, input int errs);
		test_cnt++;
		if (errs == 0)
			$display("test %0d: %0d frames ok", num, frames);
		else
			$display("test %0d: %0d frames, %0d mismatches", num, frames, errs);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		int ptr;
		int nxt_ptr;
		int cur_test;
		int test_base;
		int frames;
		int cyc;
		rst_n     = 1'b0;
		ss_n      = 1'b1;
		mosi      = 1'b0;
		err_cnt   = 0;
		chk_cnt   = 0;
		test_cnt  = 0;
		timed_out = 1'b0;
		test_base = 0;
		foreach (model[i])
			model[i] = '0;
		foreach (tdata[i])
			tdata[i] = '0;
		$readmemh("spis_testdata.txt", tdata);

		repeat (5) @(negedge sclk);
		rst_n <= 1'b1;
		cyc = 0;
		while (dbg_bus !== '0 && cyc < TIMEOUT) begin
			@(negedge sclk);
			cyc++;
		end
		if (dbg_bus !== '0) begin
			$display("Timeout: controller not idle after reset");
			timed_out = 1'b1;
		end
		repeat (8) begin  // miso quiet while deselected
			@(posedge sclk);
			check_value("miso", '0, {{(SPIS_DATA_W-1){1'b0}}, miso});
		end

		ptr      = 0;
		cur_test = int'(tdata[0]);
		frames   = 0;
		while (!timed_out && ptr < TD_SIZE && tdata[ptr] != '0) begin
			if (int'(tdata[ptr]) != cur_test) begin
				report_test(cur_test, frames, err_cnt - test_base);
				cur_test  = int'(tdata[ptr]);
				test_base = err_cnt;
				frames    = 0;
			end
			play_frame(ptr, nxt_ptr);
			ptr = nxt_ptr;
			frames++;
		end
		if (frames > 0)
			report_test(cur_test, frames, err_cnt - test_base);

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			test_cnt, chk_cnt, err_cnt, dut_i.ctrl_i.chk_i.fail_cnt);
		if (err_cnt == 0 && dut_i.ctrl_i.chk_i.fail_cnt == 0 && !timed_out) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- spis_testdata.txt
// test  command  control  data words (hex), control = {cut bits, word count}
// cut bits 0 sends all words whole, a test number of 0 ends the list
1 00000003 00000002 00000000 00000000
1 0000000c 00000002 00000000 00000000
1 20020007 00000003 00000000 00000000 00000000
2 01000005 00000001 deadbeef
2 00000005 00000002 00000000 00000000
2 21000006 00000002 0badf00d 5eed1234
2 20000006 00000003 00000000 00000000 00000000
2 00000007 00000002 00000000 00000000
3 21040008 00000004 11111111 22222222 33333333 44444444
3 20040008 00000005 00000000 00000000 00000000 00000000 00000000
4 55040008 00000004 aaaaaaaa bbbbbbbb cccccccc dddddddd
4 20040008 00000005 00000000 00000000 00000000 00000000 00000000
5 01000002 00000001 c0ffee02
5 21040000 00100003 a5a50000 a5a50001 a5a50002
5 20030000 00000004 00000000 00000000 00000000 00000000
6 01000010 00000001 12345678
6 00000010 00000002 00000000 00000000
6 2103000e 00000003 e0e0e00e f0f0f00f 10101010
6 2003000e 00000004 00000000 00000000 00000000 00000000
6 00000000 00000002 00000000 00000000
0

//--- vlog.f
spis_pkg.sv
spis_shift.sv
spis_ctrl.sv
spis_regfile.sv
spis_top.sv
spis_chk.sv
tb_spis.sv
